/* source/xfcp_i2c_pkg.sv */
// xfcp i2c port shared constants and stream payload types
`default_nettype none

package xfcp_i2c_pkg;

    // frame framing bytes
    localparam logic [7:0] START_TAG = 8'hFF;
    localparam logic [7:0] I2C_REQ   = 8'h2C;
    localparam logic [7:0] I2C_RESP  = 8'h2D;

    localparam logic [7:0] CMD_STATUS   = 8'h40;
    localparam logic [7:0] CMD_PRESCALE = 8'h60;

    // quarter bit period in clk cycles, minus one
    localparam logic [15:0] DEFAULT_PRESCALE = 16'd78;

    typedef struct packed {
        logic [7:0] data;
        logic       last;
        logic       user;
    } xfcp_beat_t;

    typedef struct packed {
        logic [6:0] address;
        logic       start;
        logic       read;
        logic       write;
        logic       stop;
        logic [7:0] wr_data;
    } i2c_cmd_t;

    // bit 0 is busy
    typedef struct packed {
        logic [3:0] reserved;
        logic       missed_ack;
        logic       bus_active;
        logic       bus_control;
        logic       busy;
    } i2c_status_t;

endpackage

`default_nettype wire

/* source/stream_reg.sv */
// two-entry skid register for a valid/ready stream of any payload type
`timescale 1ns/1ns
`default_nettype none

module stream_reg #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     clk,
    input  wire logic     rst,

    input  wire payload_t in_data_i,
    input  wire logic     in_valid_i,
    output logic          in_ready_o,

    output payload_t      out_data_o,
    output logic          out_valid_o,
    input  wire logic     out_ready_i
);

    payload_t main_q;
    payload_t skid_q;
    logic     main_valid_q;
    logic     skid_valid_q;
    logic     in_ready_q;
    logic     in_fire;
    logic     out_free;

    assign in_fire  = in_valid_i && in_ready_q;
    assign out_free = !main_valid_q || out_ready_i;

    assign in_ready_o  = in_ready_q;
    assign out_data_o  = main_q;
    assign out_valid_o = main_valid_q;

    always_ff @(posedge clk) begin
        if (out_free) begin
            // skid entry drains first to keep order
            main_valid_q <= skid_valid_q || in_fire;
            main_q       <= skid_valid_q ? skid_q : in_data_i;
            skid_valid_q <= 1'b0;
        end else if (in_fire) begin
            skid_q       <= in_data_i;
            skid_valid_q <= 1'b1;
        end

        // ready drops only once the skid entry will be full
        in_ready_q <= out_free || !(skid_valid_q || in_fire);

        if (rst) begin
            main_valid_q <= 1'b0;
            skid_valid_q <= 1'b0;
            in_ready_q   <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/xfcp_frame_parser.sv */
// xfcp frame parser: decodes i2c command bytes and builds the response stream
`timescale 1ns/1ns
`default_nettype none

module xfcp_frame_parser
    import xfcp_i2c_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,

    input  wire logic [7:0]  ds_data_i,
    input  wire logic        ds_last_i,
    input  wire logic        ds_valid_i,
    output logic             ds_ready_o,

    output xfcp_beat_t       beat_o,
    output logic             beat_valid_o,
    input  wire logic        beat_ready_i,

    output i2c_cmd_t         cmd_o,
    output logic             cmd_valid_o,
    input  wire logic        cmd_ready_i,

    input  wire logic [7:0]  rd_data_i,
    input  wire logic        rd_valid_i,
    output logic             rd_ready_o,

    input  wire logic        busy_i,
    input  wire logic        bus_control_i,
    input  wire logic        missed_ack_i,

    output logic [15:0]      prescale_o
);

    typedef enum logic [3:0] {
        S_IDLE,
        S_TYPE,
        S_CMD,
        S_STATUS,
        S_PRE_L,
        S_PRE_H,
        S_WR_DATA,
        S_RD_DATA,
        S_DRAIN
    } state_t;

    state_t      state_q;
    state_t      state_n;
    logic        last_q;
    logic        cmd_valid_q;
    logic        missed_q;
    logic [6:0]  addr_q;
    logic [15:0] prescale_q;
    i2c_cmd_t    cmd_q;
    i2c_status_t status;
    logic        ds_fire;
    logic        beat_fire;
    logic        is_op;
    logic        is_read;
    logic        is_write;

    assign ds_fire   = ds_valid_i && ds_ready_o;
    assign beat_fire = beat_valid_o && beat_ready_i;

    // bus operation bytes have the top three bits clear
    assign is_op    = ds_data_i[7:5] == 3'b000;
    assign is_read  = is_op && ds_data_i[1];
    assign is_write = is_op && ds_data_i[2] && !ds_data_i[1];

    assign cmd_o       = cmd_q;
    assign cmd_valid_o = cmd_valid_q;
    assign prescale_o  = prescale_q;

    always_comb begin
        status             = '0;
        status.busy        = busy_i;
        status.bus_control = bus_control_i;
        status.missed_ack  = missed_q;

        state_n      = state_q;
        ds_ready_o   = 1'b0;
        rd_ready_o   = 1'b0;
        beat_valid_o = 1'b0;
        beat_o.data  = ds_data_i;
        beat_o.last  = ds_last_i;
        beat_o.user  = 1'b0;

        case (state_q)
            S_IDLE: begin
                ds_ready_o   = beat_ready_i;
                beat_valid_o = ds_valid_i && ds_data_i == START_TAG && !ds_last_i;
                if (ds_fire && !ds_last_i) begin
                    state_n = (ds_data_i == START_TAG) ? S_TYPE : S_DRAIN;
                end
            end
            S_TYPE: begin
                ds_ready_o   = beat_ready_i;
                beat_valid_o = ds_valid_i;
                if (ds_data_i == I2C_REQ && !ds_last_i) begin
                    beat_o.data = I2C_RESP;
                    if (ds_fire) begin
                        state_n = S_CMD;
                    end
                end else begin
                    // error beat closes the response
                    beat_o.data = 8'h00;
                    beat_o.last = 1'b1;
                    beat_o.user = 1'b1;
                    if (ds_fire) begin
                        state_n = ds_last_i ? S_IDLE : S_DRAIN;
                    end
                end
            end
            S_CMD: begin
                ds_ready_o   = beat_ready_i && !cmd_valid_q;
                beat_valid_o = ds_valid_i && !cmd_valid_q;
                // a reply byte follows, so last moves to it
                if (ds_data_i == CMD_STATUS || is_read) begin
                    beat_o.last = 1'b0;
                end
                if (ds_fire) begin
                    if (ds_data_i == CMD_STATUS) begin
                        state_n = S_STATUS;
                    end else if (ds_data_i == CMD_PRESCALE && !ds_last_i) begin
                        state_n = S_PRE_L;
                    end else if (is_read) begin
                        state_n = S_RD_DATA;
                    end else if (is_write && !ds_last_i) begin
                        state_n = S_WR_DATA;
                    end else if (ds_last_i) begin
                        state_n = S_IDLE;
                    end
                end
            end
            S_STATUS: begin
                // report only once the engine has finished
                beat_o.data  = status;
                beat_o.last  = last_q;
                beat_valid_o = !cmd_valid_q && !busy_i;
                if (beat_fire) begin
                    state_n = last_q ? S_IDLE : S_CMD;
                end
            end
            S_PRE_L, S_PRE_H, S_WR_DATA: begin
                ds_ready_o   = beat_ready_i;
                beat_valid_o = ds_valid_i;
                if (ds_fire) begin
                    if (ds_last_i) begin
                        state_n = S_IDLE;
                    end else begin
                        state_n = (state_q == S_PRE_L) ? S_PRE_H : S_CMD;
                    end
                end
            end
            S_RD_DATA: begin
                rd_ready_o   = beat_ready_i;
                beat_o.data  = rd_data_i;
                beat_o.last  = last_q;
                beat_valid_o = rd_valid_i;
                if (beat_fire) begin
                    state_n = last_q ? S_IDLE : S_CMD;
                end
            end
            S_DRAIN: begin
                ds_ready_o = 1'b1;
                if (ds_fire && ds_last_i) begin
                    state_n = S_IDLE;
                end
            end
            default: begin
                state_n = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        state_q <= state_n;

        if (ds_fire) begin
            last_q <= ds_last_i;
        end

        if (cmd_valid_q && cmd_ready_i) begin
            cmd_valid_q <= 1'b0;
        end

        // sticky until reported
        missed_q <= missed_q || missed_ack_i;
        if (state_q == S_STATUS && beat_fire) begin
            missed_q <= missed_ack_i;
        end

        if (ds_fire) begin
            case (state_q)
                S_CMD: begin
                    if (ds_data_i[7]) begin
                        addr_q <= ds_data_i[6:0];
                    end
                    if (is_op) begin
                        cmd_q.address <= addr_q;
                        cmd_q.start   <= ds_data_i[0];
                        cmd_q.read    <= ds_data_i[1];
                        cmd_q.write   <= is_write;
                        cmd_q.stop    <= ds_data_i[3];
                        // writes go out with their data byte
                        cmd_valid_q   <= |ds_data_i[3:0] && !is_write;
                    end
                end
                S_PRE_L: prescale_q[7:0] <= ds_data_i;
                S_PRE_H: prescale_q[15:8] <= ds_data_i;
                S_WR_DATA: begin
                    cmd_q.wr_data <= ds_data_i;
                    cmd_valid_q   <= 1'b1;
                end
                default: begin
                end
            endcase
        end

        if (rst) begin
            state_q     <= S_IDLE;
            cmd_valid_q <= 1'b0;
            missed_q    <= 1'b0;
            addr_q      <= 7'd0;
            prescale_q  <= DEFAULT_PRESCALE;
        end
    end

endmodule

`default_nettype wire

/* source/i2c_byte_engine.sv */
// i2c master bit sequencer for start, single byte write or read, and stop
`timescale 1ns/1ns
`default_nettype none

module i2c_byte_engine
    import xfcp_i2c_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        rst,

    input  wire i2c_cmd_t    cmd_i,
    input  wire logic        cmd_valid_i,
    output logic             cmd_ready_o,

    output logic [7:0]       rd_data_o,
    output logic             rd_valid_o,
    input  wire logic        rd_ready_i,

    input  wire logic [15:0] prescale_i,

    input  wire logic        scl_i,
    input  wire logic        sda_i,
    output logic             scl_o,
    output logic             sda_o,

    output logic             busy_o,
    output logic             bus_control_o,
    output logic             missed_ack_o
);

    typedef enum logic [2:0] {
        E_IDLE,
        E_START,
        E_ADDR,
        E_WRITE,
        E_READ,
        E_STOP
    } elem_t;

    elem_t       elem_q;
    elem_t       elem_n;
    logic [1:0]  q_q;
    logic [15:0] cnt_q;
    logic [3:0]  bit_q;
    logic [8:0]  sh_q;
    logic [8:0]  sh_n;
    i2c_cmd_t    cmd_q;
    i2c_cmd_t    cmd_in;
    i2c_cmd_t    cur_cmd;
    logic [7:0]  rd_data_q;
    logic        rd_valid_q;
    logic        scl_q;
    logic        sda_q;
    logic        sda_lvl;
    logic        bus_q;
    logic        missed_q;
    logic        stretch;
    logic        q_done;
    logic        elem_done;
    logic        cmd_fire;

    // element that follows cur in the command
    function automatic elem_t next_elem(elem_t cur, i2c_cmd_t c);
        elem_t n;
        n = E_IDLE;
        if (cur == E_IDLE && c.start) begin
            n = E_START;
        end else if (cur == E_START && (c.read || c.write)) begin
            n = E_ADDR;
        end else if ((cur == E_IDLE || cur == E_ADDR) && c.read) begin
            n = E_READ;
        end else if ((cur == E_IDLE || cur == E_ADDR) && c.write) begin
            n = E_WRITE;
        end else if (cur != E_STOP && c.stop) begin
            n = E_STOP;
        end
        return n;
    endfunction

    always_comb begin
        cmd_in = cmd_i;
        // a transfer on a free bus needs its own start
        if (!bus_q && (cmd_i.read || cmd_i.write)) begin
            cmd_in.start = 1'b1;
        end
        cur_cmd = (elem_q == E_IDLE) ? cmd_in : cmd_q;
        elem_n  = next_elem(elem_q, cur_cmd);

        case (elem_n)
            E_ADDR: sh_n = {cur_cmd.address, cur_cmd.read, 1'b1};
            E_WRITE: sh_n = {cur_cmd.wr_data, 1'b1};
            default: sh_n = '1;
        endcase

        // start and stop move sda while scl is high
        case (elem_q)
            E_START: sda_lvl = q_q != 2'd3;
            E_STOP: sda_lvl = q_q == 2'd3;
            E_READ: sda_lvl = 1'b1;
            default: sda_lvl = sh_q[8];
        endcase
    end

    // target holding scl low stretches the clock
    assign stretch   = scl_q && !scl_i;
    assign q_done    = (elem_q != E_IDLE) && (cnt_q == '0) && !stretch;
    assign elem_done = q_done && q_q == 2'd3 &&
                       (elem_q == E_START || elem_q == E_STOP || bit_q == 4'd8);
    assign cmd_ready_o = (elem_q == E_IDLE) && !rd_valid_q;
    assign cmd_fire    = cmd_valid_i && cmd_ready_o;

    assign scl_o         = scl_q;
    assign sda_o         = sda_q;
    assign rd_data_o     = rd_data_q;
    assign rd_valid_o    = rd_valid_q;
    assign busy_o        = (elem_q != E_IDLE) || cmd_valid_i;
    assign bus_control_o = bus_q;
    assign missed_ack_o  = missed_q;

    always_ff @(posedge clk) begin
        missed_q <= 1'b0;
        if (rd_valid_q && rd_ready_i) begin
            rd_valid_q <= 1'b0;
        end

        if (cmd_fire || elem_done) begin
            if (cmd_fire) begin
                cmd_q <= cmd_in;
            end
            if (elem_q == E_ADDR || elem_q == E_WRITE) begin
                missed_q <= sda_i;
            end
            if (elem_q == E_READ) begin
                rd_data_q  <= sh_q[7:0];
                rd_valid_q <= 1'b1;
            end
            if (elem_q == E_STOP) begin
                bus_q <= 1'b0;
            end
            if (elem_n == E_START) begin
                bus_q <= 1'b1;
            end
            elem_q <= elem_n;
            // idle bus already has both lines high
            q_q    <= (elem_n == E_START && !bus_q) ? 2'd2 : 2'd0;
            cnt_q  <= prescale_i;
            bit_q  <= 4'd0;
            sh_q   <= sh_n;
        end else if (q_done) begin
            q_q   <= q_q + 2'd1;
            cnt_q <= prescale_i;
            if (q_q == 2'd3) begin
                bit_q <= bit_q + 4'd1;
                sh_q  <= {sh_q[7:0], sda_i};
            end
        end else if (elem_q != E_IDLE && !stretch) begin
            cnt_q <= cnt_q - 16'd1;
        end

        // q0 and q1 hold scl low, q2 and q3 release it
        if (elem_q != E_IDLE) begin
            scl_q <= q_q[1];
            if (q_q != 2'd0) begin
                sda_q <= sda_lvl;
            end
        end

        if (rst) begin
            elem_q     <= E_IDLE;
            rd_valid_q <= 1'b0;
            missed_q   <= 1'b0;
            bus_q      <= 1'b0;
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/xfcp_i2c_top.sv */
// xfcp i2c command port: frame parser, stream slices and i2c byte engine
`timescale 1ns/1ns
`default_nettype none

module xfcp_i2c_top
    import xfcp_i2c_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,

    input  wire logic [7:0] ds_data_i,
    input  wire logic       ds_last_i,
    input  wire logic       ds_valid_i,
    output logic            ds_ready_o,

    output logic [7:0]      us_data_o,
    output logic            us_last_o,
    output logic            us_user_o,
    output logic            us_valid_o,
    input  wire logic       us_ready_i,

    input  wire logic       scl_i,
    input  wire logic       sda_i,
    output logic            scl_o,
    output logic            sda_o
);

    xfcp_beat_t  beat;
    xfcp_beat_t  us_beat;
    logic        beat_valid;
    logic        beat_ready;
    i2c_cmd_t    cmd;
    i2c_cmd_t    eng_cmd;
    logic        cmd_valid;
    logic        cmd_ready;
    logic        eng_cmd_valid;
    logic        eng_cmd_ready;
    logic [7:0]  rd_data;
    logic        rd_valid;
    logic        rd_ready;
    logic        busy;
    logic        bus_control;
    logic        missed_ack;
    logic [15:0] prescale;

    assign us_data_o = us_beat.data;
    assign us_last_o = us_beat.last;
    assign us_user_o = us_beat.user;

    xfcp_frame_parser u_parser (
        .clk           (clk),
        .rst           (rst),
        .ds_data_i     (ds_data_i),
        .ds_last_i     (ds_last_i),
        .ds_valid_i    (ds_valid_i),
        .ds_ready_o    (ds_ready_o),
        .beat_o        (beat),
        .beat_valid_o  (beat_valid),
        .beat_ready_i  (beat_ready),
        .cmd_o         (cmd),
        .cmd_valid_o   (cmd_valid),
        .cmd_ready_i   (cmd_ready),
        .rd_data_i     (rd_data),
        .rd_valid_i    (rd_valid),
        .rd_ready_o    (rd_ready),
        .busy_i        (busy),
        .bus_control_i (bus_control),
        .missed_ack_i  (missed_ack),
        .prescale_o    (prescale)
    );

    // response path toward the host
    stream_reg #(
        .payload_t (xfcp_beat_t)
    ) u_us_reg (
        .clk         (clk),
        .rst         (rst),
        .in_data_i   (beat),
        .in_valid_i  (beat_valid),
        .in_ready_o  (beat_ready),
        .out_data_o  (us_beat),
        .out_valid_o (us_valid_o),
        .out_ready_i (us_ready_i)
    );

    stream_reg #(
        .payload_t (i2c_cmd_t)
    ) u_cmd_reg (
        .clk         (clk),
        .rst         (rst),
        .in_data_i   (cmd),
        .in_valid_i  (cmd_valid),
        .in_ready_o  (cmd_ready),
        .out_data_o  (eng_cmd),
        .out_valid_o (eng_cmd_valid),
        .out_ready_i (eng_cmd_ready)
    );

    i2c_byte_engine u_engine (
        .clk           (clk),
        .rst           (rst),
        .cmd_i         (eng_cmd),
        .cmd_valid_i   (eng_cmd_valid),
        .cmd_ready_o   (eng_cmd_ready),
        .rd_data_o     (rd_data),
        .rd_valid_o    (rd_valid),
        .rd_ready_i    (rd_ready),
        .prescale_i    (prescale),
        .scl_i         (scl_i),
        .sda_i         (sda_i),
        .scl_o         (scl_o),
        .sda_o         (sda_o),
        .busy_o        (busy),
        .bus_control_o (bus_control),
        .missed_ack_o  (missed_ack)
    );

endmodule

`default_nettype wire

/* tests/i2c_target_model.sv */
// i2c target model with one data register, open-drain outputs and clock stretching
`timescale 1ns/1ns
`default_nettype none

module i2c_target_model #(
    parameter logic [6:0] ADDR = 7'h50
) (
    input  wire logic scl_i,
    input  wire logic sda_i,
    output logic      scl_o,
    output logic      sda_o
);

    localparam int P_IDLE  = 0;
    localparam int P_ADDR  = 1;
    localparam int P_WRITE = 2;
    localparam int P_READ  = 3;

    int         phase;
    int         bit_cnt;
    logic [7:0] shift;
    logic [7:0] reg_q;

    initial begin
        scl_o   = 1'b1;
        sda_o   = 1'b1;
        phase   = P_IDLE;
        bit_cnt = 0;
        shift   = 8'h00;
        reg_q   = 8'h00;
    end

    // start and stop
    always @(negedge sda_i) begin
        if (scl_i === 1'b1) begin
            phase   = P_ADDR;
            bit_cnt = 0;
            sda_o   = 1'b1;
        end
    end

    always @(posedge sda_i) begin
        if (scl_i === 1'b1) begin
            phase = P_IDLE;
            sda_o = 1'b1;
        end
    end

    always @(posedge scl_i) begin
        if (phase != P_IDLE) begin
            if (bit_cnt < 8) begin
                shift = {shift[6:0], sda_i};
            end
            bit_cnt = bit_cnt + 1;
        end
    end

    always @(negedge scl_i) begin
        if (phase != P_IDLE) begin
            scl_o = 1'b0;
            sda_o = 1'b1;
            if (bit_cnt == 8) begin
                // ack slot
                if (phase == P_ADDR && shift[7:1] == ADDR) begin
                    sda_o = 1'b0;
                end else if (phase == P_ADDR) begin
                    phase = P_IDLE;
                end else if (phase == P_WRITE) begin
                    reg_q = shift;
                    sda_o = 1'b0;
                end
            end else if (bit_cnt == 9) begin
                bit_cnt = 0;
                if (phase == P_ADDR) begin
                    phase = shift[0] ? P_READ : P_WRITE;
                end else if (phase == P_READ) begin
                    phase = P_IDLE;
                end
            end
            if (phase == P_READ && bit_cnt < 8) begin
                sda_o = reg_q[7 - bit_cnt];
            end
            // hold scl low a little longer than the master
            #40;
            scl_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tests/xfcp_i2c_assertions.sv */
// concurrent checks on the xfcp i2c top level ports
`timescale 1ns/1ns
`default_nettype none

module xfcp_i2c_assertions (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic       ds_ready_o,
    input wire logic [7:0] us_data_o,
    input wire logic       us_last_o,
    input wire logic       us_user_o,
    input wire logic       us_valid_o,
    input wire logic       us_ready_i,
    input wire logic       scl_o,
    input wire logic       sda_o
);

    reset_idle: assert property (@(posedge clk)
        rst |=> !ds_ready_o && !us_valid_o && scl_o && sda_o)
        else $error("control outputs active after reset");

    us_stable: assert property (@(posedge clk) disable iff (rst)
        us_valid_o && !us_ready_i |=> us_valid_o && $stable({us_data_o, us_last_o, us_user_o}))
        else $error("upstream beat changed while stalled");

    // sda and scl never move on the same edge
    sda_scl_apart: assert property (@(posedge clk) disable iff (rst)
        $changed(sda_o) |-> !$changed(scl_o))
        else $error("sda and scl changed together");

    // with scl high, only start or stop after a settled high phase
    sda_high_change: assert property (@(posedge clk) disable iff (rst)
        $changed(sda_o) && scl_o |-> $past(scl_o, 2))
        else $error("sda changed while scl high outside start or stop");

endmodule

bind xfcp_i2c_top xfcp_i2c_assertions u_assertions (.*);

`default_nettype wire

/* tests/tb_xfcp_i2c.sv */
// testbench for the xfcp i2c command port, frames and responses from a stim file
`timescale 1ns/1ns
`default_nettype none

module tb_xfcp_i2c
    import xfcp_i2c_pkg::*;
();

    localparam int          MAX_WORDS = 256;
    localparam int          TIMEOUT   = 20000;
    localparam logic [31:0] SEED      = 32'h2c0d9559;

    logic       clk;
    logic       rst;
    logic [7:0] ds_data;
    logic       ds_last;
    logic       ds_valid;
    logic       ds_ready;
    logic [7:0] us_data;
    logic       us_last;
    logic       us_user;
    logic       us_valid;
    logic       us_ready;
    logic       dut_scl;
    logic       dut_sda;
    logic       tgt_scl;
    logic       tgt_sda;
    logic       scl_line;
    logic       sda_line;

    logic [15:0] stim [0:MAX_WORDS-1];
    logic [15:0] frame_q[$];
    logic [15:0] expect_q[$];
    logic [31:0] ready_rng;
    logic [31:0] gap_rng;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    // open-drain bus
    assign scl_line = dut_scl & tgt_scl;
    assign sda_line = dut_sda & tgt_sda;

    xfcp_i2c_top uut (
        .clk        (clk),
        .rst        (rst),
        .ds_data_i  (ds_data),
        .ds_last_i  (ds_last),
        .ds_valid_i (ds_valid),
        .ds_ready_o (ds_ready),
        .us_data_o  (us_data),
        .us_last_o  (us_last),
        .us_user_o  (us_user),
        .us_valid_o (us_valid),
        .us_ready_i (us_ready),
        .scl_i      (scl_line),
        .sda_i      (sda_line),
        .scl_o      (dut_scl),
        .sda_o      (dut_sda)
    );

    i2c_target_model #(
        .ADDR (7'h50)
    ) u_target (
        .scl_i (scl_line),
        .sda_i (sda_line),
        .scl_o (tgt_scl),
        .sda_o (tgt_sda)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // host stalls the response stream a quarter of the time
    always @(negedge clk) begin
        ready_rng = xorshift32(ready_rng);
        us_ready  = !rst && (ready_rng[1:0] != 2'b00);
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $finish;
    endtask

    task automatic check_beat(input xfcp_beat_t got, input xfcp_beat_t exp, input int idx);
        string exp_s;
        if (got !== exp) begin
            exp_s = $sformatf("%02h last %0b user %0b", exp.data, exp.last, exp.user);
            $display("[FAIL] %0t: beat %0d is %02h last %0b user %0b, expected %s",
                     $time, idx, got.data, got.last, got.user, exp_s);
            test_errors++;
        end
    endtask

    task automatic check_status(input i2c_status_t got, input logic got_last,
                                input logic got_user, input i2c_status_t exp,
                                input logic exp_last, input logic exp_user, input int idx);
        string got_s;
        string exp_s;
        if (got !== exp || got_last !== exp_last || got_user !== exp_user) begin
            got_s = $sformatf("busy %0b ctrl %0b missed %0b last %0b user %0b",
                              got.busy, got.bus_control, got.missed_ack, got_last, got_user);
            exp_s = $sformatf("busy %0b ctrl %0b missed %0b last %0b user %0b",
                              exp.busy, exp.bus_control, exp.missed_ack, exp_last, exp_user);
            $display("[FAIL] %0t: status beat %0d is %02h %s, expected %02h %s",
                     $time, idx, got, got_s, exp, exp_s);
            test_errors++;
        end
    endtask

    task automatic send_bytes();
        int n;
        @(negedge clk);
        foreach (frame_q[i]) begin
            gap_rng = xorshift32(gap_rng);
            if (gap_rng[2:0] == 3'd0) begin
                @(negedge clk);
            end
            ds_data  = frame_q[i][7:0];
            ds_last  = frame_q[i][9];
            ds_valid = 1'b1;
            n = 0;
            do begin
                @(posedge clk);
                n++;
                if (n > TIMEOUT) begin
                    abort_run("timeout: the DUT never accepted a frame byte");
                end
            end while (!ds_ready);
            @(negedge clk);
            ds_valid = 1'b0;
        end
    endtask

    task automatic collect_beats();
        xfcp_beat_t got;
        xfcp_beat_t exp;
        int         n;
        foreach (expect_q[i]) begin
            n = 0;
            do begin
                @(posedge clk);
                n++;
                if (n > TIMEOUT) begin
                    abort_run("timeout: an expected response beat never arrived");
                end
            end while (!(us_valid && us_ready));
            got.data = us_data;
            got.last = us_last;
            got.user = us_user;
            exp.data = expect_q[i][7:0];
            exp.last = expect_q[i][9];
            exp.user = expect_q[i][8];
            if (expect_q[i][15:12] == 4'h3) begin
                check_status(i2c_status_t'(us_data), us_last, us_user,
                             i2c_status_t'(exp.data), exp.last, exp.user, i);
            end else begin
                check_beat(got, exp, i);
            end
        end
    endtask

    // nothing more may come out once the response is complete
    task automatic watch_quiet();
        repeat (60) begin
            @(posedge clk);
            if (us_valid) begin
                $display("[FAIL] %0t: unexpected extra beat %02h", $time, us_data);
                test_errors++;
            end
        end
    endtask

    initial begin
        int idx;
        clk          = 1'b0;
        rst          = 1'b1;
        ds_data      = 8'h00;
        ds_last      = 1'b0;
        ds_valid     = 1'b0;
        us_ready     = 1'b0;
        ready_rng    = SEED;
        gap_rng      = xorshift32(SEED);
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        $readmemh("tests/xfcp_i2c_stim.txt", stim);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        idx = 0;
        while (idx < MAX_WORDS && stim[idx][15:12] != 4'hF) begin
            frame_q.delete();
            expect_q.delete();
            while (idx < MAX_WORDS && stim[idx][15:12] != 4'h4) begin
                if (stim[idx][15:12] == 4'h1) begin
                    frame_q.push_back(stim[idx]);
                end else if (stim[idx][15:12] == 4'h2 || stim[idx][15:12] == 4'h3) begin
                    expect_q.push_back(stim[idx]);
                end else begin
                    abort_run("the stim file holds a word of unknown kind");
                end
                idx++;
            end
            idx++;
            test_errors = 0;
            fork
                send_bytes();
                collect_beats();
            join
            watch_quiet();
            tests_run++;
            if (test_errors != 0) begin
                tests_failed++;
                errors += test_errors;
            end
            $display("test %0d: %s, %0d bytes in, %0d beats out", tests_run,
                     (test_errors == 0) ? "ok" : "mismatch", frame_q.size(), expect_q.size());
        end

        if (tests_run == 0) begin
            $display("no tests were read from the stim file");
            errors++;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* xfcp_i2c.f */
source/xfcp_i2c_pkg.sv
source/stream_reg.sv
source/xfcp_frame_parser.sv
source/i2c_byte_engine.sv
source/xfcp_i2c_top.sv
tests/i2c_target_model.sv
tests/xfcp_i2c_assertions.sv
tests/tb_xfcp_i2c.sv

/* Bender.yml */
package:
  name: xfcp_i2c

sources:
  - source/xfcp_i2c_pkg.sv
  - source/stream_reg.sv
  - source/xfcp_frame_parser.sv
  - source/i2c_byte_engine.sv
  - source/xfcp_i2c_top.sv
  - target: test
    files:
      - tests/i2c_target_model.sv
      - tests/xfcp_i2c_assertions.sv
      - tests/tb_xfcp_i2c.sv

/* tests/xfcp_i2c_stim.txt */
// kind in bits 15:12 (1 drive byte, 2 expect beat, 3 expect status, 4 end of test, f end)
// bit 9 is last, bit 8 is user, bits 7:0 are the byte
// prescale set to 3
10FF 102C 1060 1003 1200
20FF 202D 2060 2003 2200 4000
// write 0xa5 to address 0x50, then read it back
10FF 102C 10D0 100D 12A5 10FF 102C 120B
20FF 202D 20D0 200D 22A5 20FF 202D 200B 22A5 4000
// write to absent address 0x22, then two status queries
10FF 102C 10A2 100D 1011 1240 10FF 102C 1240
20FF 202D 20A2 200D 2011 2040 3208 20FF 202D 2040 3200 4000
// bad start byte, normal frame, bad type byte
1000 102C 1240 10FF 102C 1240 10FF 1011 1240
20FF 202D 2040 3200 20FF 2300 4000
// long frame with status and read in the middle
10FF 102C 1060 1003 1000 1040 10D0 100B 1240
20FF 202D 2060 2003 2000 2040 3000 20D0 200B 20A5 2040 3200 4000
F000
